//--- common/sdio_settings.svh
// sdio host command settings
`ifndef SDIO_SETTINGS_SVH
`define SDIO_SETTINGS_SVH

// --------------------------------------------------
// apb register map
// --------------------------------------------------
`define SDIO_APB_AW        8

`define SDIO_REG_CTRL      8'h00  // clock enable and divider
`define SDIO_REG_ARG       8'h04  // command argument
`define SDIO_REG_CMD       8'h08  // command word, write launches
`define SDIO_REG_RESP_ARG  8'h0C  // response argument, read only
`define SDIO_REG_RESP_IDX  8'h10  // response index and crc, read only
`define SDIO_REG_STATUS    8'h14  // w1c flags plus busy
`define SDIO_REG_IRQ_EN    8'h18  // per flag interrupt enable

// --------------------------------------------------
// cmd line framing
// --------------------------------------------------
`define SDIO_CMD_BITS      48     // command frame and short response
`define SDIO_CRC_BITS      7

// card clocks to wait for a response start bit
`define SDIO_NCR_MAX       64

`endif

//--- common/sdio_pkg.sv
// sdio host shared types
`default_nettype none

`include "sdio_settings.svh"

package sdio_pkg;

    // card clock setup, ctrl register
    typedef struct packed {
        logic       en;
        logic [7:0] div;   // card clock = sd_clk / ((div + 1) * 2)
    } clk_cfg_t;

    // codes 01 and 11 are reserved, treated as no response
    typedef enum logic [1:0] {
        RESP_NONE    = 2'b00,
        RESP_SHORT48 = 2'b10
    } resp_type_e;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] argument;
        resp_type_e  resp_type;
        logic        crc_check;
        logic        index_check;
        logic [5:0]  pad;
    } cmd_req_t;

    // one-cycle pulses, bit 0 is complete so it maps onto status directly
    typedef struct packed {
        logic index_err;
        logic end_err;
        logic crc_err;
        logic timeout_err;
        logic complete;
    } cmd_events_t;

    // short response, first bit on the line is the msb
    typedef struct packed {
        logic                      start;
        logic                      dir;
        logic [5:0]                index;
        logic [31:0]               argument;
        logic [`SDIO_CRC_BITS-1:0] crc;
        logic                      end_bit;
    } resp48_fields_t;

    typedef union packed {
        logic [`SDIO_CMD_BITS-1:0] raw;  // receive shift view
        resp48_fields_t            f;    // decoded view
    } resp48_u;

    typedef struct packed {
        logic [5:0]                index;
        logic [31:0]               argument;
        logic [`SDIO_CRC_BITS-1:0] crc;  // as received
    } cmd_result_t;

endpackage

`default_nettype wire

//--- verilog/sdio_clk.sv
// sdio card clock divider
`timescale 1ns/1ps
`default_nettype none

module sdio_clk (
    input  wire                     sd_clk,
    input  wire                     rst_i,
    input  wire sdio_pkg::clk_cfg_t clk_cfg_i,
    output logic                    pad_clk_o,
    output logic                    tx_stb_o,   // with the falling card clock
    output logic                    rx_stb_o    // with the rising card clock
);

    logic [$bits(clk_cfg_i.div)-1:0] div_cnt;

    // half period is div + 1 sd_clk cycles
    always_ff @(posedge sd_clk) begin
        if (rst_i || !clk_cfg_i.en) begin
            div_cnt   <= '0;
            pad_clk_o <= 1'b0;  // parked low when off
            tx_stb_o  <= 1'b0;
            rx_stb_o  <= 1'b0;
        end else begin
            tx_stb_o <= 1'b0;
            rx_stb_o <= 1'b0;
            if (div_cnt == clk_cfg_i.div) begin
                div_cnt   <= '0;
                pad_clk_o <= ~pad_clk_o;
                rx_stb_o  <= ~pad_clk_o;  // going high
                tx_stb_o  <= pad_clk_o;   // going low
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- cmd/sdio_cmd.sv
// sdio cmd line engine
`timescale 1ns/1ps
`default_nettype none

`include "sdio_settings.svh"

module sdio_cmd (
    input  wire                     sd_clk,
    input  wire                     rst_i,
    input  wire sdio_pkg::cmd_req_t cmd_req_i,
    input  wire                     cmd_start_i,
    input  wire                     tx_stb_i,
    input  wire                     rx_stb_i,
    input  wire                     pad_cmd_i,
    output logic                    pad_cmd_o,
    output logic                    pad_cmd_oe_o,
    output logic                    cmd_busy_o,
    output sdio_pkg::cmd_events_t   cmd_events_o,
    output sdio_pkg::cmd_result_t   cmd_result_o
);
    import sdio_pkg::*;

    localparam int FRAME_BITS = `SDIO_CMD_BITS;
    localparam int CRC_BITS   = `SDIO_CRC_BITS;
    localparam int BODY_BITS  = FRAME_BITS - CRC_BITS - 1;  // start bit up to argument
    localparam int CNT_W      = $clog2(FRAME_BITS + 1);
    localparam int NCR_W      = $clog2(`SDIO_NCR_MAX);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_START,
        ST_RECV,
        ST_DONE
    } state_e;

    state_e               state;
    cmd_req_t             req_q;
    logic [BODY_BITS-1:0] tx_shift;
    logic [CNT_W-1:0]     bit_cnt;   // frame position, shared by tx and rx
    logic [NCR_W-1:0]     ncr_cnt;
    logic [CRC_BITS-1:0]  crc_q;
    resp48_u              resp_q;

    // crc7, x^7 + x^3 + 1, one bit per call
    function automatic logic [CRC_BITS-1:0] crc7_next(input logic [CRC_BITS-1:0] crc,
                                                      input logic din);
        logic fb;
        fb = din ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

    always_ff @(posedge sd_clk) begin
        if (rst_i) begin
            state        <= ST_IDLE;
            pad_cmd_o    <= 1'b1;  // line idles high
            pad_cmd_oe_o <= 1'b0;
            cmd_busy_o   <= 1'b0;
            cmd_events_o <= '0;
        end else begin
            cmd_events_o <= '0;
            case (state)
                ST_IDLE: begin
                    if (cmd_start_i) begin
                        state      <= ST_SEND;
                        cmd_busy_o <= 1'b1;
                        req_q      <= cmd_req_i;
                        tx_shift   <= {1'b0, 1'b1, cmd_req_i.index, cmd_req_i.argument};
                        bit_cnt    <= '0;
                        crc_q      <= '0;
                    end
                end
                // ------------------------------------------
                // command frame, msb first
                // ------------------------------------------
                ST_SEND: begin
                    if (tx_stb_i && bit_cnt == CNT_W'(FRAME_BITS)) begin
                        pad_cmd_oe_o <= 1'b0;  // release after the end bit
                        bit_cnt      <= '0;
                        ncr_cnt      <= '0;
                        crc_q        <= '0;
                        if (req_q.resp_type == RESP_SHORT48) begin
                            state <= ST_WAIT_START;
                        end else begin
                            state                 <= ST_IDLE;
                            cmd_busy_o            <= 1'b0;
                            cmd_events_o.complete <= 1'b1;
                        end
                    end else if (tx_stb_i) begin
                        pad_cmd_oe_o <= 1'b1;
                        bit_cnt      <= bit_cnt + 1'b1;
                        if (bit_cnt < CNT_W'(BODY_BITS)) begin
                            pad_cmd_o <= tx_shift[BODY_BITS-1];
                            tx_shift  <= {tx_shift[BODY_BITS-2:0], 1'b0};
                            crc_q     <= crc7_next(crc_q, tx_shift[BODY_BITS-1]);
                        end else if (bit_cnt < CNT_W'(FRAME_BITS - 1)) begin
                            pad_cmd_o <= crc_q[CRC_BITS-1];
                            crc_q     <= {crc_q[CRC_BITS-2:0], 1'b0};
                        end else begin
                            pad_cmd_o <= 1'b1;  // end bit
                        end
                    end
                end
                // ------------------------------------------
                // response capture
                // ------------------------------------------
                ST_WAIT_START: begin
                    if (rx_stb_i && !pad_cmd_i) begin
                        state      <= ST_RECV;
                        resp_q.raw <= {resp_q.raw[FRAME_BITS-2:0], 1'b0};
                        crc_q      <= crc7_next(crc_q, 1'b0);
                        bit_cnt    <= CNT_W'(1);
                    end else if (rx_stb_i && ncr_cnt == NCR_W'(`SDIO_NCR_MAX - 1)) begin
                        state                    <= ST_IDLE;  // card never answered
                        cmd_busy_o               <= 1'b0;
                        cmd_events_o.timeout_err <= 1'b1;
                        cmd_events_o.complete    <= 1'b1;
                    end else if (rx_stb_i) begin
                        ncr_cnt <= ncr_cnt + 1'b1;
                    end
                end
                ST_RECV: begin
                    if (rx_stb_i) begin
                        resp_q.raw <= {resp_q.raw[FRAME_BITS-2:0], pad_cmd_i};
                        bit_cnt    <= bit_cnt + 1'b1;
                        if (bit_cnt < CNT_W'(BODY_BITS)) begin
                            crc_q <= crc7_next(crc_q, pad_cmd_i);
                        end
                        if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                            state <= ST_DONE;
                        end
                    end
                end
                // whole response in, run the checks
                ST_DONE: begin
                    state                  <= ST_IDLE;
                    cmd_busy_o             <= 1'b0;
                    cmd_events_o.complete  <= 1'b1;
                    cmd_events_o.crc_err   <= req_q.crc_check && (resp_q.f.crc != crc_q);
                    cmd_events_o.end_err   <= !resp_q.f.end_bit;
                    cmd_events_o.index_err <= req_q.index_check &&
                                              (resp_q.f.index != req_q.index);
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign cmd_result_o = {resp_q.f.index, resp_q.f.argument, resp_q.f.crc};

endmodule

`default_nettype wire

//--- verilog/sdio_regs.sv
// sdio apb register block
`timescale 1ns/1ps
`default_nettype none

`include "sdio_settings.svh"

module sdio_regs (
    input  wire                        sd_clk,
    input  wire                        rst_i,
    // apb
    input  wire [`SDIO_APB_AW-1:0]     paddr_i,
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire                        pwrite_i,
    input  wire [31:0]                 pwdata_i,
    // from the command engine
    input  wire                        cmd_busy_i,
    input  wire sdio_pkg::cmd_events_t cmd_events_i,
    input  wire sdio_pkg::cmd_result_t cmd_result_i,
    // apb return
    output logic [31:0]                prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    // to the clock and command blocks
    output sdio_pkg::clk_cfg_t         clk_cfg_o,
    output sdio_pkg::cmd_req_t         cmd_req_o,
    output logic                       cmd_start_o,
    output logic                       irq_o
);
    import sdio_pkg::*;

    localparam int EV_W = $bits(cmd_events_t);

    logic            wr_en;
    logic            cmd_wr;
    logic [EV_W-1:0] status_q;
    logic [EV_W-1:0] irq_en_q;
    logic [EV_W-1:0] w1c;
    cmd_result_t     resp_q;

    assign pready_o  = 1'b1;  // zero wait states
    assign pslverr_o = 1'b0;

    assign wr_en  = psel_i && penable_i && pwrite_i;  // access phase
    assign cmd_wr = wr_en && (paddr_i == `SDIO_REG_CMD) && !cmd_busy_i;
    assign w1c    = (wr_en && paddr_i == `SDIO_REG_STATUS) ? pwdata_i[EV_W-1:0] : '0;

    // --------------------------------------------------
    // control state
    // --------------------------------------------------
    always_ff @(posedge sd_clk) begin
        if (rst_i) begin
            clk_cfg_o   <= '0;
            irq_en_q    <= '0;
            status_q    <= '0;
            cmd_start_o <= 1'b0;
        end else begin
            cmd_start_o <= cmd_wr;
            // new events win over a clear in the same cycle
            status_q    <= (status_q & ~w1c) | cmd_events_i;
            if (wr_en && paddr_i == `SDIO_REG_CTRL) begin
                clk_cfg_o <= pwdata_i[$bits(clk_cfg_t)-1:0];
            end
            if (wr_en && paddr_i == `SDIO_REG_IRQ_EN) begin
                irq_en_q <= pwdata_i[EV_W-1:0];
            end
        end
    end

    // --------------------------------------------------
    // command word and response capture
    // --------------------------------------------------
    always_ff @(posedge sd_clk) begin
        if (wr_en && paddr_i == `SDIO_REG_ARG) begin
            cmd_req_o.argument <= pwdata_i;
        end
        if (cmd_wr) begin
            cmd_req_o.index       <= pwdata_i[5:0];
            cmd_req_o.resp_type   <= resp_type_e'(pwdata_i[9:8]);
            cmd_req_o.crc_check   <= pwdata_i[10];
            cmd_req_o.index_check <= pwdata_i[11];
            cmd_req_o.pad         <= '0;
        end
        if (cmd_events_i.complete) begin
            resp_q <= cmd_result_i;
        end
    end

    // read mux, valid in the access cycle
    always_comb begin
        case (paddr_i)
            `SDIO_REG_CTRL:     prdata_o = {23'd0, clk_cfg_o};
            `SDIO_REG_ARG:      prdata_o = cmd_req_o.argument;
            `SDIO_REG_CMD:      prdata_o = {20'd0, cmd_req_o.index_check, cmd_req_o.crc_check,
                                            cmd_req_o.resp_type, 2'd0, cmd_req_o.index};
            `SDIO_REG_RESP_ARG: prdata_o = resp_q.argument;
            `SDIO_REG_RESP_IDX: prdata_o = {17'd0, resp_q.crc, 2'd0, resp_q.index};
            `SDIO_REG_STATUS:   prdata_o = {23'd0, cmd_busy_i, 3'd0, status_q};
            `SDIO_REG_IRQ_EN:   prdata_o = {27'd0, irq_en_q};
            default:            prdata_o = '0;
        endcase
    end

    assign irq_o = |(status_q & irq_en_q);  // masked flags

endmodule

`default_nettype wire

//--- verilog/sdio_top.sv
// sdio host command controller
`timescale 1ns/1ps
`default_nettype none

`include "sdio_settings.svh"

module sdio_top (
    // global
    input  wire                    sd_clk,
    input  wire                    rst_i,
    // apb slave
    input  wire [`SDIO_APB_AW-1:0] paddr_i,
    input  wire                    psel_i,
    input  wire                    penable_i,
    input  wire                    pwrite_i,
    input  wire [31:0]             pwdata_i,
    output wire [31:0]             prdata_o,
    output wire                    pready_o,
    output wire                    pslverr_o,
    // pads
    output wire                    pad_clk_o,
    input  wire                    pad_cmd_i,
    output wire                    pad_cmd_o,
    output wire                    pad_cmd_oe_o,
    // interrupt
    output wire                    irq_o
);

    sdio_pkg::clk_cfg_t    clk_cfg;
    sdio_pkg::cmd_req_t    cmd_req;
    sdio_pkg::cmd_events_t cmd_events;
    sdio_pkg::cmd_result_t cmd_result;
    wire                   tx_stb, rx_stb;
    wire                   cmd_start, cmd_busy;

    // --------------------------------------------------
    // registers, flags and irq
    // --------------------------------------------------
    sdio_regs u0_regs (
        .sd_clk       ( sd_clk       ),
        .rst_i        ( rst_i        ),
        .paddr_i      ( paddr_i      ),
        .psel_i       ( psel_i       ),
        .penable_i    ( penable_i    ),
        .pwrite_i     ( pwrite_i     ),
        .pwdata_i     ( pwdata_i     ),
        .cmd_busy_i   ( cmd_busy     ),
        .cmd_events_i ( cmd_events   ),
        .cmd_result_i ( cmd_result   ),
        .prdata_o     ( prdata_o     ),
        .pready_o     ( pready_o     ),
        .pslverr_o    ( pslverr_o    ),
        .clk_cfg_o    ( clk_cfg      ),
        .cmd_req_o    ( cmd_req      ),
        .cmd_start_o  ( cmd_start    ),
        .irq_o        ( irq_o        )
    );

    // card clock
    sdio_clk u1_clk (
        .sd_clk       ( sd_clk       ),
        .rst_i        ( rst_i        ),
        .clk_cfg_i    ( clk_cfg      ),
        .pad_clk_o    ( pad_clk_o    ),
        .tx_stb_o     ( tx_stb       ),
        .rx_stb_o     ( rx_stb       )
    );

    // cmd line engine
    sdio_cmd u2_cmd (
        .sd_clk       ( sd_clk       ),
        .rst_i        ( rst_i        ),
        .cmd_req_i    ( cmd_req      ),
        .cmd_start_i  ( cmd_start    ),
        .tx_stb_i     ( tx_stb       ),
        .rx_stb_i     ( rx_stb       ),
        .pad_cmd_i    ( pad_cmd_i    ),
        .pad_cmd_o    ( pad_cmd_o    ),
        .pad_cmd_oe_o ( pad_cmd_oe_o ),
        .cmd_busy_o   ( cmd_busy     ),
        .cmd_events_o ( cmd_events   ),
        .cmd_result_o ( cmd_result   )
    );

endmodule

`default_nettype wire

//--- test/sdio_assert.sv
// cmd engine protocol checks
`timescale 1ns/1ps
`default_nettype none

module sdio_assert (
    input wire                        sd_clk,
    input wire                        rst_i,
    input wire                        cmd_start_i,
    input wire                        tx_stb_i,
    input wire                        cmd_line_i,
    input wire                        cmd_oe_i,
    input wire sdio_pkg::cmd_events_t cmd_events_i
);

    logic pending;  // started, not yet completed

    always_ff @(posedge sd_clk) begin
        if (rst_i)
            pending <= 1'b0;
        else if (cmd_start_i)
            pending <= 1'b1;
        else if (cmd_events_i.complete)
            pending <= 1'b0;
    end

    a_oe_reset: assert property (@(posedge sd_clk) rst_i |=> !cmd_oe_i)
        else $error("cmd output enable high after reset");

    // the line only moves on the edge after a transmit strobe
    a_line_stb: assert property (@(posedge sd_clk) disable iff (rst_i)
        !$stable(cmd_line_i) |-> $past(tx_stb_i))
        else $error("cmd line changed without a transmit strobe");

    a_one_done: assert property (@(posedge sd_clk) disable iff (rst_i)
        cmd_events_i.complete |-> pending)
        else $error("complete without an open command");

    a_no_overlap: assert property (@(posedge sd_clk) disable iff (rst_i)
        cmd_start_i |-> !pending)
        else $error("command start before the previous complete");

endmodule

bind sdio_cmd sdio_assert u_assert (
    .sd_clk       ( sd_clk       ),
    .rst_i        ( rst_i        ),
    .cmd_start_i  ( cmd_start_i  ),
    .tx_stb_i     ( tx_stb_i     ),
    .cmd_line_i   ( pad_cmd_o    ),
    .cmd_oe_i     ( pad_cmd_oe_o ),
    .cmd_events_i ( cmd_events_o )
);

`default_nettype wire

//--- test/sdio_tb.sv
// sdio command controller testbench
`timescale 1ns/1ps
`default_nettype none

`include "sdio_settings.svh"

module sdio_tb;
    import sdio_pkg::*;

    localparam int     NUM_CMDS = 40;
    // longest command at divider 3, plus apb traffic
    localparam longint LIMIT_NS = NUM_CMDS * (`SDIO_CMD_BITS + `SDIO_NCR_MAX + 20) * 2 * 4 * 10
                                  + 100000;
    localparam int     GOOD = 0, BAD_CRC = 1, END0 = 2, BAD_IDX = 3, SILENT = 4;
    localparam int     CARD_LISTEN = 0, CARD_DELAY = 1, CARD_REPLY = 2;

    logic                    sd_clk, rst_i, psel, penable, pwrite;
    logic                    pad_cmd_i = 1'b1;
    logic [`SDIO_APB_AW-1:0] paddr;
    logic [31:0]             pwdata;
    wire  [31:0]             prdata;
    wire                     pready, pslverr, pad_clk, pad_cmd, pad_cmd_oe, irq;
    int                      seed = 18;
    int                      mismatch_cnt = 0;
    int                      fail_cnt = 0;
    int                      frame_cnt = 0;
    int                      card_mode, card_delay, card_wait, card_cnt, card_state;
    logic [31:0]             card_arg;
    logic                    clk_prev, card_rise, card_fall;
    resp48_u                 card_frame, card_resp;

    sdio_top sdio_top_i (
        .sd_clk    ( sd_clk  ), .rst_i     ( rst_i   ), .paddr_i      ( paddr      ),
        .psel_i    ( psel    ), .penable_i ( penable ), .pwrite_i     ( pwrite     ),
        .pwdata_i  ( pwdata  ), .prdata_o  ( prdata  ), .pready_o     ( pready     ),
        .pslverr_o ( pslverr ), .pad_clk_o ( pad_clk ), .pad_cmd_i    ( pad_cmd_i  ),
        .pad_cmd_o ( pad_cmd ), .irq_o     ( irq     ), .pad_cmd_oe_o ( pad_cmd_oe )
    );

    initial begin
        sd_clk = 1'b0;
        forever #5 sd_clk = ~sd_clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout, the run did not finish within %0d ns", LIMIT_NS);
        $display("** FAIL **");
        $finish;
    end

    // x^7 + x^3 + 1 over the 40 leading frame bits
    function automatic logic [6:0] crc7_of(input logic [39:0] body);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = body[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // --------------------------------------------------
    // compare and report
    // --------------------------------------------------
    task automatic note_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        $display("MISMATCH %0t %s expected %h actual %h", $time, name, exp, got);
        mismatch_cnt++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %0t %s", $time, what);
        fail_cnt++;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp)
            note_mismatch(name, exp, got);
    endtask

    task automatic check_status(input cmd_events_t exp, input cmd_events_t got);
        if (got !== exp)
            note_mismatch("status flags", exp, got);
    endtask

    task automatic check_resp(input cmd_result_t exp, input cmd_result_t got);
        if (got.index !== exp.index)
            note_mismatch("resp index", exp.index, got.index);
        if (got.argument !== exp.argument)
            note_mismatch("resp argument", exp.argument, got.argument);
        if (got.crc !== exp.crc)
            note_mismatch("resp crc", exp.crc, got.crc);
    endtask

    task automatic check_frame(input cmd_req_t req, input resp48_u frame);
        resp48_u exp;
        exp.f.start    = 1'b0;
        exp.f.dir      = 1'b1;  // host to card
        exp.f.index    = req.index;
        exp.f.argument = req.argument;
        exp.f.crc      = crc7_of(exp.raw[47:8]);
        exp.f.end_bit  = 1'b1;
        if (frame.raw !== exp.raw)
            note_mismatch("pad_cmd_o frame", exp.raw, frame.raw);
    endtask

    // --------------------------------------------------
    // apb master, setup then access
    // --------------------------------------------------
    task automatic apb_write(input logic [`SDIO_APB_AW-1:0] addr, input logic [31:0] data);
        @(posedge sd_clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        @(posedge sd_clk);
        penable <= 1'b1;
        @(negedge sd_clk);
        check_word("pready_o", 32'd1, {31'd0, pready});
        check_word("pslverr_o", 32'd0, {31'd0, pslverr});
        @(posedge sd_clk);  // write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [`SDIO_APB_AW-1:0] addr, output logic [31:0] data);
        @(posedge sd_clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        @(posedge sd_clk);
        penable <= 1'b1;
        @(negedge sd_clk);
        data = prdata;  // mid access cycle
        check_word("pready_o", 32'd1, {31'd0, pready});
        check_word("pslverr_o", 32'd0, {31'd0, pslverr});
        @(posedge sd_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // card model, captures on the rising card clock and answers on the falling one
    always @(posedge sd_clk) begin
        if (rst_i) begin
            pad_cmd_i  <= 1'b1;
            clk_prev   = 1'b0;
            card_state = CARD_LISTEN;
            card_cnt   = 0;
        end else begin
            card_rise = pad_clk && !clk_prev;
            card_fall = !pad_clk && clk_prev;
            clk_prev  = pad_clk;
            case (card_state)
                CARD_LISTEN: begin
                    if (card_rise && pad_cmd_oe) begin
                        card_frame.raw = {card_frame.raw[46:0], pad_cmd};
                        card_cnt       = card_cnt + 1;
                    end
                    if (card_cnt == `SDIO_CMD_BITS) begin
                        card_cnt             = 0;
                        frame_cnt            = frame_cnt + 1;
                        card_resp.f.start    = 1'b0;
                        card_resp.f.dir      = 1'b0;
                        card_resp.f.index    = card_frame.f.index ^
                                               ((card_mode == BAD_IDX) ? 6'h15 : 6'h00);
                        card_resp.f.argument = card_arg;
                        card_resp.f.crc      = crc7_of(card_resp.raw[47:8]) ^
                                               ((card_mode == BAD_CRC) ? 7'h41 : 7'h00);
                        card_resp.f.end_bit  = (card_mode != END0);
                        card_wait            = card_delay;
                        if (card_mode != SILENT)
                            card_state = CARD_DELAY;
                    end
                end
                CARD_DELAY: begin
                    if (card_fall && card_wait <= 1) begin
                        if (pad_cmd_oe)
                            report_failure("host still drives cmd at the response start");
                        pad_cmd_i  <= card_resp.raw[47];  // start bit
                        card_cnt   = 1;
                        card_state = CARD_REPLY;
                    end else if (card_fall) begin
                        card_wait = card_wait - 1;
                    end
                end
                default: begin
                    if (card_fall && card_cnt == `SDIO_CMD_BITS) begin
                        pad_cmd_i  <= 1'b1;  // back to idle high
                        card_cnt   = 0;
                        card_state = CARD_LISTEN;
                    end else if (card_fall) begin
                        pad_cmd_i <= card_resp.raw[47-card_cnt];
                        card_cnt  = card_cnt + 1;
                    end
                end
            endcase
        end
    end

    initial begin
        logic [31:0] rd, pick, mask, word, en;
        cmd_req_t    req;
        cmd_result_t got_res;
        cmd_events_t exp_ev;
        logic        short_rsp;
        rst_i   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge sd_clk);
        rst_i <= 1'b0;

        // register readback
        apb_read(`SDIO_REG_STATUS, rd);
        check_word("STATUS", 32'd0, rd);
        pick = $random(seed);
        apb_write(`SDIO_REG_CTRL, pick);
        apb_read(`SDIO_REG_CTRL, rd);
        check_word("CTRL", pick & 32'h1FF, rd);
        pick = $random(seed);
        apb_write(`SDIO_REG_ARG, pick);
        apb_read(`SDIO_REG_ARG, rd);
        check_word("ARG", pick, rd);
        pick = $random(seed);
        apb_write(`SDIO_REG_IRQ_EN, pick);
        apb_read(`SDIO_REG_IRQ_EN, rd);
        check_word("IRQ_EN", pick & 32'h1F, rd);

        for (int n = 0; n < NUM_CMDS; n++) begin
            pick            = $random(seed);
            mask            = $random(seed);
            req             = '0;
            req.index       = pick[5:0];
            req.argument    = $random(seed);
            req.resp_type   = resp_type_e'(pick[6] ? 2'b10 : pick[8:7]);  // 01 and 11 reserved
            req.crc_check   = pick[9];
            req.index_check = pick[10];
            short_rsp       = (req.resp_type == RESP_SHORT48);
            card_mode       = short_rsp ? int'(pick[18:11] % 5) : SILENT;
            card_delay      = 2 + int'(pick[26:19] % 19);
            card_arg        = $random(seed);
            en              = {27'd0, pick[31:27]};
            word            = {20'd0, req.index_check, req.crc_check, req.resp_type,
                               2'd0, req.index};
            apb_write(`SDIO_REG_CTRL, 32'd0);  // restart divider from zero
            apb_write(`SDIO_REG_CTRL, {23'd0, 1'b1, 6'd0, mask[1:0]});
            apb_write(`SDIO_REG_IRQ_EN, en);
            apb_write(`SDIO_REG_ARG, req.argument);
            apb_write(`SDIO_REG_CMD, word);
            apb_read(`SDIO_REG_STATUS, rd);
            if (!rd[8])
                report_failure("busy not set after a command write");
            apb_write(`SDIO_REG_CMD, ~word);  // must be dropped while busy
            apb_read(`SDIO_REG_CMD, rd);
            check_word("CMD", word, rd);
            apb_read(`SDIO_REG_STATUS, rd);
            while (!rd[0]) begin
                apb_read(`SDIO_REG_STATUS, rd);
            end
            if (frame_cnt != n + 1)
                report_failure("card saw a wrong number of command frames");
            check_frame(req, card_frame);
            exp_ev             = '0;
            exp_ev.complete    = 1'b1;
            exp_ev.timeout_err = short_rsp && card_mode == SILENT;
            exp_ev.crc_err     = card_mode == BAD_CRC && req.crc_check;
            exp_ev.end_err     = card_mode == END0;
            exp_ev.index_err   = card_mode == BAD_IDX && req.index_check;
            check_status(exp_ev, rd[4:0]);
            if (rd[8])
                report_failure("busy still set after complete");
            @(negedge sd_clk);
            check_word("irq_o", {31'd0, |(exp_ev & en[4:0])}, {31'd0, irq});
            if (pad_cmd_oe)
                report_failure("cmd output enable still high after complete");
            if (short_rsp && card_mode != SILENT) begin
                apb_read(`SDIO_REG_RESP_ARG, rd);
                got_res.argument = rd;
                apb_read(`SDIO_REG_RESP_IDX, rd);
                got_res.index = rd[5:0];
                got_res.crc   = rd[14:8];
                check_resp({card_resp.f.index, card_resp.f.argument, card_resp.f.crc}, got_res);
            end
            // partial then full clear
            apb_write(`SDIO_REG_STATUS, {27'd0, mask[8:4]});
            apb_read(`SDIO_REG_STATUS, rd);
            check_status(exp_ev & ~mask[8:4], rd[4:0]);
            apb_write(`SDIO_REG_STATUS, 32'h1F);
            apb_read(`SDIO_REG_STATUS, rd);
            check_word("STATUS", 32'd0, rd);
            check_word("irq_o", 32'd0, {31'd0, irq});
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/sdio_pkg.sv
verilog/sdio_clk.sv
cmd/sdio_cmd.sv
verilog/sdio_regs.sv
verilog/sdio_top.sv
test/sdio_assert.sv
test/sdio_tb.sv

//--- Makefile
OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module sdio_tb -Mdir $(OBJ) -f all.f

run: compile
	./$(OBJ)/Vsdio_tb | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
